//--- verilog/fpuPkg.sv
package fpuPkg;

	// raw command word, [7:6] condition code, [5:0] opcode
	typedef logic [8:0] uCmd_t;
	typedef logic [8:0] uIxt_t;		// opcode extension

	typedef logic [63:0] dword_t;
	typedef logic [31:0] sword_t;
	typedef logic [15:0] hword_t;

	typedef logic [2:0] convKind_t;
	typedef logic [1:0] statusOk_t;

	// opcodes handled by this unit
	localparam logic [5:0] UCMD_NOP   = 6'h00;
	localparam logic [5:0] UCMD_FPU3  = 6'h1C;
	localparam logic [5:0] UCMD_FLDCX = 6'h1D;
	localparam logic [5:0] UCMD_FSTCX = 6'h1E;

	// condition codes
	localparam logic [1:0] CC_AL = 2'd0;
	localparam logic [1:0] CC_NV = 2'd1;
	localparam logic [1:0] CC_CT = 2'd2;	// run if T set
	localparam logic [1:0] CC_CF = 2'd3;	// run if T clear

	// operation kinds after decode
	localparam convKind_t KIND_NONE = 3'd0;
	localparam convKind_t KIND_MOVE = 3'd1;
	localparam convKind_t KIND_S2D  = 3'd2;
	localparam convKind_t KIND_H2D  = 3'd3;
	localparam convKind_t KIND_D2S  = 3'd4;
	localparam convKind_t KIND_D2H  = 3'd5;
	localparam convKind_t KIND_PAIR = 3'd6;	// narrowed single over low Rs word

	// execute status
	localparam statusOk_t OK_READY = 2'd0;
	localparam statusOk_t OK_OK    = 2'd1;
	localparam statusOk_t OK_HOLD  = 2'd2;

	// IEEE format field widths
	localparam int SGL_EXP_BITS = 8;
	localparam int SGL_MAN_BITS = 23;
	localparam int HLF_EXP_BITS = 5;
	localparam int HLF_MAN_BITS = 10;
	localparam int DBL_EXP_BITS = 11;
	localparam int DBL_MAN_BITS = 52;

	typedef struct packed {
		uCmd_t  cmd;
		uIxt_t  ixt;
		dword_t rs;
	} fpuLaneCmd_t;

	typedef struct packed {
		logic      active;
		convKind_t kind;
		logic      highHalf;	// FLDCX source from Rs[63:32]
		dword_t    rs;
	} fpuIssue_t;

	typedef struct packed {
		statusOk_t status;
		dword_t    value;
	} fpuResult_t;

endpackage

//--- verilog/fpuIssueDecode.sv
`timescale 1ns/1ps

module fpuIssueDecode (
	input  logic                clock,
	input  logic                reset,
	input  logic                hold,
	input  fpuPkg::fpuLaneCmd_t laneA,
	input  fpuPkg::fpuLaneCmd_t laneB,
	input  logic                statusT,
	input  logic                flush,
	output fpuPkg::fpuIssue_t   issue
);

	fpuPkg::fpuLaneCmd_t picked;
	fpuPkg::uCmd_t       cmdL;
	fpuPkg::uIxt_t       ixtL;
	fpuPkg::dword_t      rsL;
	logic                statusTL;
	logic                flushL;
	logic                opEnable;
	fpuPkg::convKind_t   kind;

	function automatic logic isFpuCmd(input fpuPkg::uCmd_t cmd);
		return (cmd[5:0] == fpuPkg::UCMD_FPU3) ||
			(cmd[5:0] == fpuPkg::UCMD_FLDCX) ||
			(cmd[5:0] == fpuPkg::UCMD_FSTCX);
	endfunction

	// lane A wins when both carry an FPU op
	assign picked = (!isFpuCmd(laneA.cmd) && isFpuCmd(laneB.cmd)) ? laneB : laneA;

	always_ff @(posedge clock) begin
		if (reset) begin
			cmdL     <= {1'b0, fpuPkg::CC_AL, fpuPkg::UCMD_NOP};
			statusTL <= 1'b0;
			flushL   <= 1'b0;
		end else if (!hold) begin
			cmdL     <= picked.cmd;
			statusTL <= statusT;
			flushL   <= flush;
		end
	end

	always_ff @(posedge clock) begin
		if (!hold) begin
			ixtL <= picked.ixt;
			rsL  <= picked.rs;
		end
	end

	// predication on the latched copy
	always_comb begin
		casez ({flushL, cmdL[7:6], statusTL})
			4'b000?: opEnable = 1'b1;	// AL
			4'b001?: opEnable = 1'b0;	// NV
			4'b0100: opEnable = 1'b0;
			4'b0101: opEnable = 1'b1;	// CT, T set
			4'b0110: opEnable = 1'b1;	// CF, T clear
			4'b0111: opEnable = 1'b0;
			default: opEnable = 1'b0;	// flushed
		endcase
	end

	always_comb begin
		kind = fpuPkg::KIND_NONE;
		case (cmdL[5:0])
			fpuPkg::UCMD_FPU3: begin
				if (ixtL[3:0] == 4'h4)
					kind = fpuPkg::KIND_MOVE;
			end
			fpuPkg::UCMD_FLDCX: begin
				case (ixtL[2:0])	// bit 3 picks the half, not the op
					3'h0: kind = fpuPkg::KIND_S2D;
					3'h1: kind = fpuPkg::KIND_MOVE;
					3'h3: kind = fpuPkg::KIND_H2D;
					default: kind = fpuPkg::KIND_NONE;
				endcase
			end
			fpuPkg::UCMD_FSTCX: begin
				case (ixtL[3:0])
					4'h0: kind = fpuPkg::KIND_D2S;
					4'h1: kind = fpuPkg::KIND_MOVE;
					4'h3: kind = fpuPkg::KIND_D2H;
					4'h8: kind = fpuPkg::KIND_PAIR;
					default: kind = fpuPkg::KIND_NONE;
				endcase
			end
			default: kind = fpuPkg::KIND_NONE;
		endcase
	end

	assign issue = '{
		active:   opEnable && (kind != fpuPkg::KIND_NONE),
		kind:     kind,
		highHalf: (cmdL[5:0] == fpuPkg::UCMD_FLDCX) && ixtL[3],
		rs:       rsL
	};

	// a held pipeline must not drop or take a command
	assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable({cmdL, ixtL, rsL}));

endmodule

//--- verilog/fpuWiden.sv
`timescale 1ns/1ps

module fpuWiden #(
	parameter int ExpBits = 8,
	parameter int ManBits = 23
) (
	input  logic [ExpBits+ManBits:0] source,
	output fpuPkg::dword_t           widened
);

	localparam int DblExp = fpuPkg::DBL_EXP_BITS;
	localparam int DblMan = fpuPkg::DBL_MAN_BITS;
	// difference of the two exponent biases
	localparam int BiasDelta = ((1 << (DblExp - 1)) - 1) - ((1 << (ExpBits - 1)) - 1);

	logic              sign;
	logic [ExpBits-1:0] expIn;
	logic [ManBits-1:0] manIn;
	logic [DblExp-1:0]  expOut;
	logic [DblMan-1:0]  manOut;

	assign sign  = source[ExpBits+ManBits];
	assign expIn = source[ExpBits+ManBits-1:ManBits];
	assign manIn = source[ManBits-1:0];

	assign expOut = DblExp'(expIn) + DblExp'(BiasDelta);
	assign manOut = {manIn, {(DblMan - ManBits){1'b0}}};	// left aligned

	always_comb begin
		if (expIn == '0) begin
			// denormals flush to zero
			widened = {sign, {(DblExp + DblMan){1'b0}}};
		end else if (&expIn) begin
			widened = {sign, {DblExp{1'b1}}, manOut};	// inf / NaN
		end else begin
			widened = {sign, expOut, manOut};
		end
	end

endmodule

//--- verilog/fpuNarrow.sv
`timescale 1ns/1ps

module fpuNarrow #(
	parameter int ExpBits = 8,
	parameter int ManBits = 23
) (
	input  fpuPkg::dword_t           source,
	output logic [ExpBits+ManBits:0] narrowed
);

	localparam int DblExp  = fpuPkg::DBL_EXP_BITS;
	localparam int DblMan  = fpuPkg::DBL_MAN_BITS;
	localparam int DblBias = (1 << (DblExp - 1)) - 1;
	localparam int Bias    = (1 << (ExpBits - 1)) - 1;
	localparam int MaxExp  = (1 << ExpBits) - 1;	// all-ones field

	logic                     sign;
	logic [DblExp-1:0]        expIn;
	logic [DblMan-1:0]        manIn;
	logic signed [DblExp+1:0] rebiased;	// two spare bits for sign and range
	logic [ManBits-1:0]       manTrunc;

	assign sign     = source[DblExp+DblMan];
	assign expIn    = source[DblExp+DblMan-1:DblMan];
	assign manIn    = source[DblMan-1:0];
	assign manTrunc = manIn[DblMan-1:DblMan-ManBits];	// round toward zero

	assign rebiased = $signed({2'b00, expIn}) - $signed((DblExp + 2)'(DblBias - Bias));

	always_comb begin
		if (&expIn) begin
			if (manIn == '0) begin
				narrowed = {sign, {ExpBits{1'b1}}, {ManBits{1'b0}}};
			end else begin
				// keep it a NaN even if the kept bits are zero
				narrowed = {sign, {ExpBits{1'b1}}, 1'b1, manTrunc[ManBits-2:0]};
			end
		end else if (expIn == '0) begin
			narrowed = {sign, {(ExpBits + ManBits){1'b0}}};
		end else if (rebiased <= 0) begin
			narrowed = {sign, {(ExpBits + ManBits){1'b0}}};	// underflow
		end else if (rebiased >= MaxExp) begin
			narrowed = {sign, {ExpBits{1'b1}}, {ManBits{1'b0}}};	// overflow to inf
		end else begin
			narrowed = {sign, rebiased[ExpBits-1:0], manTrunc};
		end
	end

endmodule

//--- verilog/fpuConvExecute.sv
`timescale 1ns/1ps

module fpuConvExecute (
	input  fpuPkg::fpuIssue_t  issue,
	output fpuPkg::fpuResult_t opResult
);

	fpuPkg::sword_t srcWord;
	fpuPkg::dword_t widenS;
	fpuPkg::dword_t widenH;
	fpuPkg::sword_t narrowS;
	fpuPkg::hword_t narrowH;
	fpuPkg::dword_t opValue;

	// load source half, ixt bit 3 picks the upper word
	assign srcWord = issue.highHalf ? issue.rs[63:32] : issue.rs[31:0];

	fpuWiden #(
		.ExpBits(fpuPkg::SGL_EXP_BITS),
		.ManBits(fpuPkg::SGL_MAN_BITS)
	) u_widenS (
		.source (srcWord),
		.widened(widenS)
	);

	fpuWiden #(
		.ExpBits(fpuPkg::HLF_EXP_BITS),
		.ManBits(fpuPkg::HLF_MAN_BITS)
	) u_widenH (
		.source (srcWord[15:0]),
		.widened(widenH)
	);

	fpuNarrow #(
		.ExpBits(fpuPkg::SGL_EXP_BITS),
		.ManBits(fpuPkg::SGL_MAN_BITS)
	) u_narrowS (
		.source  (issue.rs),
		.narrowed(narrowS)
	);

	fpuNarrow #(
		.ExpBits(fpuPkg::HLF_EXP_BITS),
		.ManBits(fpuPkg::HLF_MAN_BITS)
	) u_narrowH (
		.source  (issue.rs),
		.narrowed(narrowH)
	);

	always_comb begin
		case (issue.kind)
			fpuPkg::KIND_MOVE: opValue = issue.rs;
			fpuPkg::KIND_S2D:  opValue = widenS;
			fpuPkg::KIND_H2D:  opValue = widenH;
			fpuPkg::KIND_D2S:  opValue = {32'h0, narrowS};
			fpuPkg::KIND_D2H:  opValue = {48'h0, narrowH};
			fpuPkg::KIND_PAIR: opValue = {narrowS, issue.rs[31:0]};
			default:           opValue = '0;
		endcase
	end

	// predicated-off or unknown ops report ready with a zero value
	assign opResult.status = issue.active ? fpuPkg::OK_OK : fpuPkg::OK_READY;
	assign opResult.value  = issue.active ? opValue : '0;

endmodule

//--- verilog/fpuResultStage.sv
`timescale 1ns/1ps

module fpuResultStage (
	input  logic               clock,
	input  logic               reset,
	input  logic               hold,
	input  fpuPkg::fpuResult_t opResult,
	output fpuPkg::fpuResult_t result
);

	fpuPkg::fpuResult_t resultL;

	always_ff @(posedge clock) begin
		if (reset) begin
			resultL.status <= fpuPkg::OK_READY;
			resultL.value  <= '0;
		end else if (!hold) begin
			resultL <= opResult;
		end
	end

	assign result = resultL;

	// result must not move while the pipe is frozen
	assert property (@(posedge clock) disable iff (reset)
		hold |=> $stable(result));

	// every op here is single cycle, the unit never asks for a hold itself
	assert property (@(posedge clock) disable iff (reset)
		result.status != fpuPkg::OK_HOLD);

endmodule

//--- verilog/fpuConvUnit.sv
`timescale 1ns/1ps

module fpuConvUnit (
	input  logic                clock,
	input  logic                reset,
	input  logic                hold,
	input  fpuPkg::fpuLaneCmd_t laneA,
	input  fpuPkg::fpuLaneCmd_t laneB,
	input  logic                statusT,
	input  logic                flush,
	output fpuPkg::fpuResult_t  result
);

	fpuPkg::fpuIssue_t  issue;
	fpuPkg::fpuResult_t opResult;	// combinational, registered in the result stage

	fpuIssueDecode u_decode (
		.clock  (clock),
		.reset  (reset),
		.hold   (hold),
		.laneA  (laneA),
		.laneB  (laneB),
		.statusT(statusT),
		.flush  (flush),
		.issue  (issue)
	);

	fpuConvExecute u_execute (
		.issue   (issue),
		.opResult(opResult)
	);

	fpuResultStage u_result (
		.clock   (clock),
		.reset   (reset),
		.hold    (hold),
		.opResult(opResult),
		.result  (result)
	);

endmodule

//--- testbench/fpuConvChecks.svh
`ifndef FPU_CONV_CHECKS_SVH
`define FPU_CONV_CHECKS_SVH

function automatic fpuPkg::fpuLaneCmd_t makeLane(input logic [1:0] cc, input logic [5:0] op,
		input fpuPkg::uIxt_t ixt, input fpuPkg::dword_t rs);
	fpuPkg::fpuLaneCmd_t lane;
	lane.cmd = {1'b0, cc, op};
	lane.ixt = ixt;
	lane.rs  = rs;
	return lane;
endfunction

function automatic fpuPkg::fpuLaneCmd_t idleLane();
	return makeLane(fpuPkg::CC_AL, fpuPkg::UCMD_NOP, 9'h000, 64'h0);
endfunction

function automatic fpuPkg::fpuLaneCmd_t loadLane(input fpuPkg::uIxt_t ixt, input fpuPkg::dword_t rs);
	return makeLane(fpuPkg::CC_AL, fpuPkg::UCMD_FLDCX, ixt, rs);
endfunction

function automatic fpuPkg::fpuLaneCmd_t storeLane(input fpuPkg::uIxt_t ixt, input fpuPkg::dword_t rs);
	return makeLane(fpuPkg::CC_AL, fpuPkg::UCMD_FSTCX, ixt, rs);
endfunction

function automatic fpuPkg::fpuLaneCmd_t condMove(input logic [1:0] cc, input fpuPkg::dword_t rs);
	return makeLane(cc, fpuPkg::UCMD_FSTCX, 9'h001, rs);
endfunction

// smaller IEEE format to double, denormals become signed zero
function automatic fpuPkg::dword_t widenRef(input logic [31:0] src, input int eBits,
		input int mBits);
	logic [31:0] e;
	logic [63:0] m;
	logic [63:0] res;
	e = (src >> mBits) & ((32'd1 << eBits) - 32'd1);
	m = 64'(src & ((32'd1 << mBits) - 32'd1)) << (52 - mBits);
	if (e == 32'd0)
		res = 64'd0;
	else if (e == (32'd1 << eBits) - 32'd1)
		res = {1'b0, 11'h7FF, m[51:0]};
	else
		res = {1'b0, 11'(e + 32'd1023 - ((32'd1 << (eBits - 1)) - 32'd1)), m[51:0]};
	res[63] = src[eBits + mBits];
	return res;
endfunction

// double to smaller format, mantissa truncated
function automatic logic [31:0] narrowRef(input fpuPkg::dword_t d, input int eBits,
		input int mBits);
	int          e;
	int          ne;
	int          maxE;
	logic [31:0] mt;
	logic [31:0] res;
	e    = int'(d[62:52]);
	maxE = (1 << eBits) - 1;
	ne   = e - 1023 + ((1 << (eBits - 1)) - 1);
	mt   = 32'(d[51:0] >> (52 - mBits));
	if (e == 2047 && d[51:0] == 52'd0)
		res = 32'(maxE) << mBits;
	else if (e == 2047)
		res = (32'(maxE) << mBits) | mt | (32'd1 << (mBits - 1));	// quiet bit keeps NaN
	else if (e == 0 || ne <= 0)
		res = 32'd0;
	else if (ne >= maxE)
		res = 32'(maxE) << mBits;
	else
		res = (32'(ne) << mBits) | mt;
	res[eBits + mBits] = d[63];
	return res;
endfunction

task automatic checkValue(input string what, input fpuPkg::dword_t got,
		input fpuPkg::dword_t want);
	if (got !== want) begin
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
		failRun();
	end
endtask

task automatic checkStatus(input string what, input fpuPkg::statusOk_t got,
		input fpuPkg::statusOk_t want);
	if (got !== want) begin
		$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
		failRun();
	end
endtask

task automatic compareResult(input fpuPkg::statusOk_t st, input fpuPkg::dword_t val);
	checkStatus("result.status", result.status, st);
	checkValue("result.value", result.value, val);
endtask

// lanes change just after a rising edge
task automatic driveLanes(input fpuPkg::fpuLaneCmd_t a, input fpuPkg::fpuLaneCmd_t b,
		input logic t, input logic fl);
	@(posedge clock);
	#1;
	laneA   = a;
	laneB   = b;
	statusT = t;
	flush   = fl;
endtask

task automatic runOp(input fpuPkg::fpuLaneCmd_t a, input fpuPkg::fpuLaneCmd_t b,
		input logic t, input logic fl, input fpuPkg::statusOk_t st, input fpuPkg::dword_t val);
	driveLanes(a, b, t, fl);
	@(posedge clock);	// taken into decode
	@(posedge clock);	// result register
	#1;
	compareResult(st, val);
endtask

task automatic runOnLaneA(input fpuPkg::fpuLaneCmd_t a, input fpuPkg::dword_t val);
	runOp(a, idleLane(), 1'b0, 1'b0, fpuPkg::OK_OK, val);
endtask

`endif

//--- testbench/fpuConvUnitTb.sv
`timescale 1ns/1ps

module fpuConvUnitTb;

	localparam int ResetCycles = 10;
	// widen 32 + narrow 30 + moves 6 + predication 8 + lanes 3 + hold 3 drive calls
	localparam int DriveCalls    = 82;
	localparam int TimeoutCycles = DriveCalls * 4 + ResetCycles;

	localparam logic [31:0] SglVectors [6] = '{
		32'h3FC00000, 32'h00000000, 32'h80000000, 32'h7F800000, 32'h7FC00001, 32'h80012345
	};
	localparam logic [15:0] HlfVectors [6] = '{
		16'h3C00, 16'h0000, 16'hFC00, 16'h7E01, 16'h0123, 16'hC555
	};
	// 1.5, -pi, single overflow, single underflow, -inf, NaN with only a low payload bit
	localparam fpuPkg::dword_t DblVectors [6] = '{
		64'h3FF8000000000000, 64'hC00921FB54442D18, 64'h47F0000000000000,
		64'h3800000000000000, 64'hFFF0000000000000, 64'h7FF0000000000001
	};

	logic                clock;
	logic                reset;
	logic                hold;
	fpuPkg::fpuLaneCmd_t laneA;
	fpuPkg::fpuLaneCmd_t laneB;
	logic                statusT;
	logic                flush;
	fpuPkg::fpuResult_t  result;
	integer              seed;
	int                  cycleCount = 0;

	fpuConvUnit u_dut (
		.clock  (clock),
		.reset  (reset),
		.hold   (hold),
		.laneA  (laneA),
		.laneB  (laneB),
		.statusT(statusT),
		.flush  (flush),
		.result (result)
	);

	always #2 clock = ~clock;

	task automatic failRun();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	`include "fpuConvChecks.svh"

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("timeout, the tests did not finish within %0d cycles", TimeoutCycles);
			failRun();
		end
	end

	function automatic logic [31:0] randomSingle();
		logic [31:0] r;
		r     = $random(seed);
		r[30] = ~r[29];	// exponent never all zeros or all ones
		return r;
	endfunction

	function automatic logic [15:0] randomHalf();
		logic [31:0] r;
		r     = $random(seed);
		r[14] = ~r[13];
		return r[15:0];
	endfunction

	function automatic fpuPkg::dword_t randomDouble();
		fpuPkg::dword_t d;
		d[63:32] = $random(seed);
		d[31:0]  = $random(seed);
		d[61:59] = d[62] ? 3'b000 : 3'b111;	// keep the exponent near the single range
		return d;
	endfunction

	task automatic widenLoads();
		logic [31:0] r;
		logic [31:0] s;
		logic [15:0] h;
		for (int i = 0; i < 6; i++) begin
			r = $random(seed);
			s = SglVectors[i];
			h = HlfVectors[i];
			runOnLaneA(loadLane(9'h000, {r, s}), widenRef(s, 8, 23));
			runOnLaneA(loadLane(9'h008, {s, r}), widenRef(s, 8, 23));
			runOnLaneA(loadLane(9'h003, {r, r[15:0], h}), widenRef({16'h0, h}, 5, 10));
			runOnLaneA(loadLane(9'h00B, {r[15:0], h, r}), widenRef({16'h0, h}, 5, 10));
		end
		for (int i = 0; i < 4; i++) begin
			s = randomSingle();
			h = randomHalf();
			r = $random(seed);
			runOnLaneA(loadLane(9'h000, {r, s}), widenRef(s, 8, 23));
			runOnLaneA(loadLane(9'h00B, {r[15:0], h, r}), widenRef({16'h0, h}, 5, 10));
		end
	endtask

	task automatic narrowAll(input fpuPkg::dword_t d);
		runOnLaneA(storeLane(9'h000, d), {32'h0, narrowRef(d, 8, 23)});
		runOnLaneA(storeLane(9'h003, d), {32'h0, narrowRef(d, 5, 10)});
		runOnLaneA(storeLane(9'h008, d), {narrowRef(d, 8, 23), d[31:0]});	// store pair
	endtask

	task automatic narrowStores();
		for (int i = 0; i < 6; i++)
			narrowAll(DblVectors[i]);
		for (int i = 0; i < 4; i++)
			narrowAll(randomDouble());
	endtask

	task automatic plainMoves();
		fpuPkg::dword_t d;
		for (int i = 0; i < 2; i++) begin
			d[63:32] = $random(seed);
			d[31:0]  = $random(seed);
			runOnLaneA(loadLane(9'h001, d), d);
			runOnLaneA(storeLane(9'h001, d), d);
			runOnLaneA(makeLane(fpuPkg::CC_AL, fpuPkg::UCMD_FPU3, 9'h004, d), d);
		end
	endtask

	task automatic predication();
		fpuPkg::dword_t v;
		v = randomDouble();
		runOp(condMove(fpuPkg::CC_CT, v), idleLane(), 1'b1, 1'b0, fpuPkg::OK_OK, v);
		runOp(condMove(fpuPkg::CC_CT, v), idleLane(), 1'b0, 1'b0, fpuPkg::OK_READY, 64'h0);
		runOp(condMove(fpuPkg::CC_CF, v), idleLane(), 1'b0, 1'b0, fpuPkg::OK_OK, v);
		runOp(condMove(fpuPkg::CC_CF, v), idleLane(), 1'b1, 1'b0, fpuPkg::OK_READY, 64'h0);
		runOp(condMove(fpuPkg::CC_NV, v), idleLane(), 1'b0, 1'b0, fpuPkg::OK_READY, 64'h0);
		runOp(condMove(fpuPkg::CC_AL, v), idleLane(), 1'b0, 1'b1, fpuPkg::OK_READY, 64'h0);
		runOp(storeLane(9'h005, v), idleLane(), 1'b0, 1'b0, fpuPkg::OK_READY, 64'h0);
		// neither lane carries an FPU opcode
		runOp(idleLane(), makeLane(fpuPkg::CC_AL, 6'h05, 9'h001, v), 1'b0, 1'b0,
			fpuPkg::OK_READY, 64'h0);
	endtask

	task automatic laneSelection();
		fpuPkg::dword_t va;
		fpuPkg::dword_t vb;
		va = randomDouble();
		vb = randomDouble();
		runOp(makeLane(fpuPkg::CC_AL, fpuPkg::UCMD_NOP, 9'h001, va), storeLane(9'h001, vb),
			1'b0, 1'b0, fpuPkg::OK_OK, vb);
		runOp(storeLane(9'h001, va), storeLane(9'h001, vb), 1'b0, 1'b0, fpuPkg::OK_OK, va);
		runOp(makeLane(fpuPkg::CC_AL, 6'h05, 9'h001, va), storeLane(9'h000, vb), 1'b0, 1'b0,
			fpuPkg::OK_OK, {32'h0, narrowRef(vb, 8, 23)});
	endtask

	task automatic holdFreeze();
		fpuPkg::dword_t v1;
		fpuPkg::dword_t v2;
		v1 = randomDouble();
		v2 = randomDouble();
		driveLanes(storeLane(9'h001, v1), idleLane(), 1'b0, 1'b0);
		driveLanes(storeLane(9'h000, v2), idleLane(), 1'b0, 1'b0);
		@(posedge clock);	// second command taken while the first one is on result
		#1;
		hold = 1'b1;
		compareResult(fpuPkg::OK_OK, v1);
		driveLanes(idleLane(), idleLane(), 1'b0, 1'b0);	// must not be taken while held
		compareResult(fpuPkg::OK_OK, v1);
		repeat (2) begin
			@(posedge clock);
			#1;
			compareResult(fpuPkg::OK_OK, v1);
		end
		hold = 1'b0;
		@(posedge clock);
		#1;
		compareResult(fpuPkg::OK_OK, {32'h0, narrowRef(v2, 8, 23)});
		@(posedge clock);
		#1;
		compareResult(fpuPkg::OK_READY, 64'h0);
	endtask

	initial begin
		clock      = 1'b0;
		reset      = 1'b1;
		hold       = 1'b0;
		statusT    = 1'b0;
		flush      = 1'b0;
		laneA      = idleLane();
		laneB      = idleLane();
		seed       = 32'h8447;
		repeat (ResetCycles) @(posedge clock);
		#1;
		reset = 1'b0;
		compareResult(fpuPkg::OK_READY, 64'h0);
		widenLoads();
		narrowStores();
		plainMoves();
		predication();
		laneSelection();
		holdFreeze();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- src.f
+incdir+testbench
verilog/fpuPkg.sv
verilog/fpuIssueDecode.sv
verilog/fpuWiden.sv
verilog/fpuNarrow.sv
verilog/fpuConvExecute.sv
verilog/fpuResultStage.sv
verilog/fpuConvUnit.sv
testbench/fpuConvUnitTb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module fpuConvUnitTb -f src.f -Mdir obj_dir
	./obj_dir/VfpuConvUnitTb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
